// ==== design/alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

    localparam int xlen    = 64;
    localparam int lg_xlen = 6;     // log2 of xlen, shift amount and iteration count
    localparam int word_w  = 32;
    localparam int half_w  = 16;

    // operation codes seen by the execute unit
    typedef enum logic [4:0] {
        add, sub,
        and_op, or_op, xor_op,
        sll, srl, sra,
        slt, sltu,
        beq, bne, blt, bge, bltu, bgeu,   // branch compares
        mul,
        divu, remu,
        divw, remw
    } alu_op_e;

    // true for ops handled by the iterative units
    function automatic logic is_multi_cycle(input alu_op_e op);
        return op inside {mul, divu, remu, divw, remw};
    endfunction

endpackage

`default_nettype wire

// ==== design/alu_res_pkg.sv ====
`default_nettype none

package alu_res_pkg;

    import alu_op_pkg::*;

    // result reshaping applied before the result register
    typedef enum logic [1:0] {
        ext_full,    // pass through
        ext_sword,   // sign extend low word
        ext_zword,   // zero extend low word
        ext_shalf    // sign extend low half
    } res_ext_e;

    // divider operand types
    typedef logic [xlen-1:0]   dword_t;
    typedef logic [word_w-1:0] word_t;

endpackage

`default_nettype wire

// ==== design/md_if.sv ====
`default_nettype none

interface md_if
    import alu_op_pkg::*;
();

    logic            req;        // one cycle start pulse
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic            fn_rem;     // remainder instead of quotient
    logic            fn_signed;
    logic            ack;        // one cycle, res valid with it
    logic [xlen-1:0] res;

    modport master (
        output req, opa, opb, fn_rem, fn_signed,
        input  ack, res
    );

    modport slave (
        input  req, opa, opb, fn_rem, fn_signed,
        output ack, res
    );

endinterface

`default_nettype wire

// ==== design/int_alu.sv ====
`default_nettype none

module int_alu
    import alu_op_pkg::*;
(
    input  alu_op_e         op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] alu_res,
    output logic            cmp_flag
);

    logic [lg_xlen-1:0] shamt;
    logic [xlen-1:0]    diff;
    logic               eq;
    logic               lt_s;
    logic               lt_u;

    assign shamt = src2[lg_xlen-1:0];   // only the low six bits count
    assign diff  = src1 - src2;

    // compare terms shared by slt and the branches
    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    always_comb begin
        case (op)
            add: begin
                alu_res = src1 + src2;
            end
            sub: begin
                alu_res = diff;
            end
            and_op: begin
                alu_res = src1 & src2;
            end
            or_op: begin
                alu_res = src1 | src2;
            end
            xor_op: begin
                alu_res = src1 ^ src2;
            end
            sll: begin
                alu_res = src1 << shamt;
            end
            srl: begin
                alu_res = src1 >> shamt;
            end
            sra: begin
                alu_res = $signed(src1) >>> shamt;   // keeps the sign bit
            end
            slt: begin
                alu_res = {{(xlen-1){1'b0}}, lt_s};
            end
            sltu: begin
                alu_res = {{(xlen-1){1'b0}}, lt_u};
            end
            default: begin
                alu_res = diff;   // branches, and ops owned by the iterative units
            end
        endcase
    end

    // branch taken flag
    always_comb begin
        case (op)
            beq: begin
                cmp_flag = eq;
            end
            bne: begin
                cmp_flag = ~eq;
            end
            blt: begin
                cmp_flag = lt_s;
            end
            bge: begin
                cmp_flag = ~lt_s;
            end
            bltu: begin
                cmp_flag = lt_u;
            end
            bgeu: begin
                cmp_flag = ~lt_u;
            end
            default: begin
                cmp_flag = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mul_unit.sv ====
`default_nettype none

module mul_unit
    import alu_op_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    md_if.slave  bus
);

    logic               run;
    logic               ack_q;
    logic [lg_xlen-1:0] cnt;
    logic [xlen-1:0]    mcand;    // shifts left each step
    logic [xlen-1:0]    mplier;   // shifts right, lsb picks the add
    logic [xlen-1:0]    acc;

    // iteration control, one product bit per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run   <= 1'b0;
            ack_q <= 1'b0;
            cnt   <= '0;
        end else begin
            ack_q <= 1'b0;
            if (bus.req && !run) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (&cnt) begin   // last of xlen steps
                    run   <= 1'b0;
                    ack_q <= 1'b1;
                end
            end
        end
    end

    // low half of the product is the same for signed and unsigned operands
    always_ff @(posedge clk) begin
        if (bus.req && !run) begin
            mcand  <= bus.opa;
            mplier <= bus.opb;
            acc    <= '0;
        end else if (run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign bus.ack = ack_q;
    assign bus.res = acc;   // settled by the time ack rises

endmodule

`default_nettype wire

// ==== design/div_unit.sv ====
`default_nettype none

module div_unit
    import alu_op_pkg::*;
    import alu_res_pkg::*;
#(
    parameter type operand_t = dword_t
)(
    input  logic clk,
    input  logic rst_n,
    md_if.slave  bus
);

    operand_t                  a_in;
    operand_t                  b_in;
    operand_t                  a_mag;
    operand_t                  b_mag;
    logic                      a_neg;
    logic                      b_neg;
    logic                      run;
    logic                      ack_q;
    logic                      sel_rem;
    logic                      neg_q;
    logic                      neg_r;
    logic [lg_xlen-1:0]        cnt;
    operand_t                  quo;     // dividend shifts out, quotient shifts in
    operand_t                  part;    // partial remainder
    operand_t                  dvs;
    logic [$bits(operand_t):0] shifted;
    logic [$bits(operand_t):0] trial;
    operand_t                  res_w;

    // operands cut to the unit width, signed ones turned into magnitudes
    assign a_in  = operand_t'(bus.opa);
    assign b_in  = operand_t'(bus.opb);
    assign a_neg = bus.fn_signed & a_in[$bits(operand_t)-1];
    assign b_neg = bus.fn_signed & b_in[$bits(operand_t)-1];
    assign a_mag = a_neg ? operand_t'(~a_in + 1'b1) : a_in;
    assign b_mag = b_neg ? operand_t'(~b_in + 1'b1) : b_in;

    assign shifted = {part, quo[$bits(operand_t)-1]};
    assign trial   = shifted - {1'b0, dvs};   // msb set means restore

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run     <= 1'b0;
            ack_q   <= 1'b0;
            cnt     <= '0;
            sel_rem <= 1'b0;
            neg_q   <= 1'b0;
            neg_r   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (bus.req && !run) begin
                run     <= 1'b1;
                cnt     <= '0;
                sel_rem <= bus.fn_rem;
                // zero divisor keeps the all ones quotient unsigned
                neg_q   <= (a_neg ^ b_neg) && (b_in != '0);
                neg_r   <= a_neg;   // remainder follows the dividend
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (cnt == lg_xlen'($bits(operand_t) - 1)) begin
                    run   <= 1'b0;
                    ack_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req && !run) begin
            quo  <= a_mag;
            dvs  <= b_mag;
            part <= '0;
        end else if (run) begin
            if (!trial[$bits(operand_t)]) begin
                part <= trial[$bits(operand_t)-1:0];
                quo  <= {quo[$bits(operand_t)-2:0], 1'b1};
            end else begin
                part <= shifted[$bits(operand_t)-1:0];
                quo  <= {quo[$bits(operand_t)-2:0], 1'b0};
            end
        end
    end

    // sign fix-up, most negative / -1 falls out as the dividend with rem 0
    always_comb begin
        if (sel_rem) begin
            res_w = neg_r ? operand_t'(~part + 1'b1) : part;
        end else begin
            res_w = neg_q ? operand_t'(~quo + 1'b1) : quo;
        end
    end

    assign bus.ack = ack_q;
    assign bus.res = xlen'(signed'(res_w));   // word results sign extended

endmodule

`default_nettype wire

// ==== design/exec_ctrl.sv ====
`default_nettype none

module exec_ctrl
    import alu_op_pkg::*;
    import alu_res_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_op_e         op,
    input  res_ext_e        ext,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] alu_res,
    input  logic            alu_cmp,
    md_if.master            mul_m,
    md_if.master            div64_m,
    md_if.master            div32_m,
    output logic [xlen-1:0] result,
    output logic            cmp_flag,
    output logic            done,
    output logic            busy
);

    alu_op_e         op_q;
    res_ext_e        ext_q;
    logic            accept;
    logic            multi;
    logic            is_branch;
    logic            fin;        // result loaded, done goes out next edge
    logic            req_mul;
    logic            req_d64;
    logic            req_d32;
    logic [xlen-1:0] opa_q;
    logic [xlen-1:0] opb_q;
    logic            fn_rem_q;
    logic            fn_signed_q;
    logic            unit_ack;
    logic [xlen-1:0] unit_res;

    function automatic logic [xlen-1:0] apply_ext(input logic [xlen-1:0] v,
                                                   input res_ext_e mode);
        case (mode)
            ext_sword: return {{(xlen-word_w){v[word_w-1]}}, v[word_w-1:0]};
            ext_zword: return {{(xlen-word_w){1'b0}}, v[word_w-1:0]};
            ext_shalf: return {{(xlen-half_w){v[half_w-1]}}, v[half_w-1:0]};
            default:   return v;
        endcase
    endfunction

    assign accept    = start & ~busy;   // start while busy is dropped
    assign multi     = is_multi_cycle(op);
    assign is_branch = op inside {beq, bne, blt, bge, bltu, bgeu};

    // pick the unit that owns the op in flight
    always_comb begin
        case (op_q)
            mul: begin
                unit_ack = mul_m.ack;
                unit_res = mul_m.res;
            end
            divu, remu: begin
                unit_ack = div64_m.ack;
                unit_res = div64_m.res;
            end
            default: begin
                unit_ack = div32_m.ack;
                unit_res = div32_m.res;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q     <= add;
            ext_q    <= ext_full;
            busy     <= 1'b0;
            done     <= 1'b0;
            fin      <= 1'b0;
            req_mul  <= 1'b0;
            req_d64  <= 1'b0;
            req_d32  <= 1'b0;
            result   <= '0;
            cmp_flag <= 1'b0;
        end else begin
            done    <= 1'b0;
            req_mul <= 1'b0;
            req_d64 <= 1'b0;
            req_d32 <= 1'b0;
            fin     <= busy & unit_ack;
            if (accept) begin
                op_q  <= op;
                ext_q <= ext;
                if (multi) begin
                    busy    <= 1'b1;
                    req_mul <= (op == mul);
                    req_d64 <= op inside {divu, remu};
                    req_d32 <= op inside {divw, remw};
                end else begin
                    result   <= apply_ext(alu_res, ext);   // single cycle path
                    cmp_flag <= is_branch & alu_cmp;
                    done     <= 1'b1;
                end
            end
            if (busy && unit_ack) begin
                result   <= apply_ext(unit_res, ext_q);
                cmp_flag <= 1'b0;
            end
            if (fin) begin
                done <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

    // operands and function bits for the iterative units
    always_ff @(posedge clk) begin
        if (accept && multi) begin
            opa_q       <= src1;
            opb_q       <= src2;
            fn_rem_q    <= op inside {remu, remw};
            fn_signed_q <= op inside {divw, remw};
        end
    end

    assign mul_m.req       = req_mul;
    assign mul_m.opa       = opa_q;
    assign mul_m.opb       = opb_q;
    assign mul_m.fn_rem    = fn_rem_q;
    assign mul_m.fn_signed = fn_signed_q;

    assign div64_m.req       = req_d64;
    assign div64_m.opa       = opa_q;
    assign div64_m.opb       = opb_q;
    assign div64_m.fn_rem    = fn_rem_q;
    assign div64_m.fn_signed = fn_signed_q;

    assign div32_m.req       = req_d32;
    assign div32_m.opa       = opa_q;
    assign div32_m.opb       = opb_q;
    assign div32_m.fn_rem    = fn_rem_q;
    assign div32_m.fn_signed = fn_signed_q;

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`default_nettype none

module exec_unit
    import alu_op_pkg::*;
    import alu_res_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_op_e         op,
    input  res_ext_e        ext,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result,
    output logic            cmp_flag,
    output logic            done,
    output logic            busy
);

    logic [xlen-1:0] alu_res;
    logic            alu_cmp;

    // one bus per iterative unit
    md_if mul_bus ();
    md_if div64_bus ();
    md_if div32_bus ();

    int_alu u_alu (
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .alu_res  (alu_res),
        .cmp_flag (alu_cmp)
    );

    exec_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .ext      (ext),
        .src1     (src1),
        .src2     (src2),
        .alu_res  (alu_res),
        .alu_cmp  (alu_cmp),
        .mul_m    (mul_bus.master),
        .div64_m  (div64_bus.master),
        .div32_m  (div32_bus.master),
        .result   (result),
        .cmp_flag (cmp_flag),
        .done     (done),
        .busy     (busy)
    );

    mul_unit u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mul_bus.slave)
    );

    div_unit #(.operand_t(dword_t)) u_div64 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (div64_bus.slave)
    );

    div_unit #(.operand_t(word_t)) u_div32 (   // divw and remw
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (div32_bus.slave)
    );

endmodule

`default_nettype wire

// ==== sim/exec_unit_assert.sv ====
`default_nettype none

module exec_unit_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       done,
    input logic       busy,
    input logic [2:0] req,     // bit 0 mul, bit 1 div64, bit 2 div32
    input logic [2:0] ack
);

    logic [2:0] pend;   // req seen, ack still owed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            pend <= (pend | req) & ~ack;
        end
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for two cycles");

    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done high in the same cycle");

    for (genvar i = 0; i < 3; i++) begin : g_bus
        req_idle: assert property (@(posedge clk) disable iff (!rst_n) req[i] |-> !pend[i])
            else $error("req on bus %0d before the previous ack", i);

        ack_owed: assert property (@(posedge clk) disable iff (!rst_n) ack[i] |-> pend[i])
            else $error("ack on bus %0d without a pending req", i);
    end

endmodule

bind exec_ctrl exec_unit_assert u_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .done  (done),
    .busy  (busy),
    .req   ({req_d32, req_d64, req_mul}),
    .ack   ({div32_m.ack, div64_m.ack, mul_m.ack})
);

`default_nettype wire

// ==== sim/exec_unit_tb.sv ====
`default_nettype none

module exec_unit_tb
    import alu_op_pkg::*;
    import alu_res_pkg::*;
();

    localparam int clk_period = 40;
    localparam int max_wait   = 300;   // edges before a wait gives up

    logic            clk;
    logic            rst_n;
    logic            start;
    alu_op_e         op;
    res_ext_e        ext;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] result;
    logic            cmp_flag;
    logic            done;
    logic            busy;

    int n_pass;
    int n_fail;

    exec_unit exec_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .ext      (ext),
        .src1     (src1),
        .src2     (src2),
        .result   (result),
        .cmp_flag (cmp_flag),
        .done     (done),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic op_by_name(input string s, output alu_op_e o);
        alu_op_e e;
        e = e.first();
        o = add;
        for (int i = 0; i < e.num(); i++) begin
            if (e.name() == s) begin
                o = e;
                return 1'b1;
            end
            e = e.next();
        end
        return 1'b0;
    endfunction

    function automatic logic ext_by_name(input string s, output res_ext_e x);
        res_ext_e e;
        e = e.first();
        x = ext_full;
        for (int i = 0; i < e.num(); i++) begin
            if (e.name() == s) begin
                x = e;
                return 1'b1;
            end
            e = e.next();
        end
        return 1'b0;
    endfunction

    // issue one op, wait for done, check result and flag
    task automatic run_test(input string name, input alu_op_e o, input res_ext_e x,
                            input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                            input logic [xlen-1:0] exp_res, input logic exp_cmp,
                            output logic hung);
        int   edges;
        int   errs;
        logic multi;
        errs  = 0;
        hung  = 1'b0;
        multi = o inside {mul, divu, remu, divw, remw};
        op    = o;
        ext   = x;
        src1  = a;
        src2  = b;
        start = 1'b1;
        @(posedge clk);
        #1;
        edges = 1;
        if (multi) begin
            op   = add;   // second start while busy, to be dropped
            src1 = ~a;
        end else begin
            start = 1'b0;
        end
        while (!done && edges < max_wait) begin
            assert (!multi || busy) else begin
                $display("%s: busy dropped before done", name);
                errs++;
            end
            @(posedge clk);
            #1;
            start = 1'b0;
            edges++;
        end
        if (!done) begin
            $display("%s: done never arrived within %0d cycles", name, max_wait);
            errs++;
            hung = 1'b1;
        end else begin
            assert (multi || edges == 1) else begin
                $display("%s: done came %0d edges after start instead of 1", name, edges);
                errs++;
            end
            assert (result === exp_res) else begin
                $display("Mismatch %s: result got %h expected %h", name, result, exp_res);
                errs++;
            end
            assert (cmp_flag === exp_cmp) else begin
                $display("Mismatch %s: cmp_flag got %h expected %h", name, cmp_flag, exp_cmp);
                errs++;
            end
            repeat (2) begin   // exactly one done per request
                @(posedge clk);
                #1;
                assert (!done) else begin
                    $display("%s: a second done followed the request", name);
                    errs++;
                end
            end
        end
        if (errs == 0) begin
            n_pass++;
            $display("%s: pass", name);
        end else begin
            n_fail++;
            $display("%s: FAIL", name);
        end
    endtask

    initial begin
        string           line;
        string           name;
        string           op_s;
        string           ext_s;
        int              fd;
        int              n;
        alu_op_e         o;
        res_ext_e        x;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] er;
        logic            ec;
        logic            hung;
        n_pass = 0;
        n_fail = 0;
        hung   = 1'b0;
        rst_n  = 1'b0;
        start  = 1'b0;
        op     = add;
        ext    = ext_full;
        src1   = '0;
        src2   = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("sim/exec_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/exec_golden.txt");
            n_fail++;
        end else begin
            while (!hung && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;   // blank or column notes
                end
                n = $sscanf(line, "%s %s %s %h %h %h %h", name, op_s, ext_s, a, b, er, ec);
                if (n != 7 || !op_by_name(op_s, o) || !ext_by_name(ext_s, x)) begin
                    $display("unreadable line in the golden file: %s", line);
                    n_fail++;
                    continue;
                end
                run_test(name, o, x, a, b, er, ec, hung);
            end
            $fclose(fd);
        end
        $display("%0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/exec_golden.txt ====
# name op ext src1 src2 expected_result expected_cmp_flag
# ops and modes by name, values in hex
add_basic   add    ext_full  0000000000000005 0000000000000007 000000000000000c 0
sub_wrap    sub    ext_full  0000000000000001 0000000000000002 ffffffffffffffff 0
and_mix     and_op ext_full  ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 0f000f000f000f00 0
xor_mix     xor_op ext_full  ff00ff00ff00ff00 0f0f0f0f0f0f0f0f f00ff00ff00ff00f 0
sll_low6    sll    ext_full  0000000000000001 0000000000000043 0000000000000008 0
srl_top     srl    ext_full  8000000000000000 000000000000003f 0000000000000001 0
sra_neg     sra    ext_full  8000000000000000 0000000000000004 f800000000000000 0
slt_minneg  slt    ext_full  8000000000000000 0000000000000001 0000000000000001 0
sltu_minneg sltu   ext_full  8000000000000000 0000000000000001 0000000000000000 0
beq_equal   beq    ext_full  0000000000001234 0000000000001234 0000000000000000 1
bne_equal   bne    ext_full  0000000000001234 0000000000001234 0000000000000000 0
blt_minneg  blt    ext_full  8000000000000000 0000000000000001 7fffffffffffffff 1
bge_minneg  bge    ext_full  8000000000000000 0000000000000001 7fffffffffffffff 0
bltu_minneg bltu   ext_full  8000000000000000 0000000000000001 7fffffffffffffff 0
bgeu_minneg bgeu   ext_full  8000000000000000 0000000000000001 7fffffffffffffff 1
addw_sext   add    ext_sword 000000007fffffff 0000000000000001 ffffffff80000000 0
addw_zext   add    ext_zword ffffffff7fffffff 0000000000000001 0000000080000000 0
addh_sext   add    ext_shalf 0000000000007fff 0000000000000001 ffffffffffff8000 0
mul_mixed   mul    ext_full  fffffffffffffffd 0000000000000007 ffffffffffffffeb 0
mul_wrap    mul    ext_full  0000000100000001 00000000ffffffff ffffffffffffffff 0
divu_basic  divu   ext_full  0000000000000064 0000000000000007 000000000000000e 0
remu_basic  remu   ext_full  0000000000000064 0000000000000007 0000000000000002 0
divu_zero   divu   ext_full  0000000000000064 0000000000000000 ffffffffffffffff 0
remu_zero   remu   ext_full  0000000000000064 0000000000000000 0000000000000064 0
divw_neg    divw   ext_full  fffffffffffffff9 0000000000000002 fffffffffffffffd 0
remw_neg    remw   ext_full  fffffffffffffff9 0000000000000002 ffffffffffffffff 0
divw_zero   divw   ext_full  0000000000000005 0000000000000000 ffffffffffffffff 0
remw_zero   remw   ext_full  fffffffffffffff9 0000000000000000 fffffffffffffff9 0
divw_ovf    divw   ext_full  0000000080000000 00000000ffffffff ffffffff80000000 0
remw_ovf    remw   ext_full  0000000080000000 00000000ffffffff 0000000000000000 0

// ==== filelist.f ====
design/alu_op_pkg.sv
design/alu_res_pkg.sv
design/md_if.sv
design/int_alu.sv
design/mul_unit.sv
design/div_unit.sv
design/exec_ctrl.sv
design/exec_unit.sv
sim/exec_unit_assert.sv
sim/exec_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the exec_unit testbench, the log decides the outcome
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exec_unit_tb \
    -f filelist.f -o exec_unit_sim > build.log 2>&1 \
    && ./obj_dir/exec_unit_sim > sim.log 2>&1 \
    || echo "tests failed" >> sim.log
cat build.log sim.log
! grep -q "tests failed" sim.log
